//--- design/id_pkg.sv
`default_nettype none

package id_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef enum logic [6:0] {
        OP_EXE   = 7'b0110011,
        OP_EXEI  = 7'b0010011,
        OP_LUI   = 7'b0110111,
        OP_AUIPC = 7'b0010111,
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011
    } opcode_e;

    typedef enum logic [4:0] {
        EX_NOP = 5'd0,
        EX_ADD, EX_SUB, EX_XOR, EX_OR, EX_AND,
        EX_SLL, EX_SRL, EX_SRA, EX_SLT, EX_SLTU,
        EX_AUIPC,
        EX_LB, EX_LH, EX_LW, EX_LBU, EX_LHU,
        EX_SB, EX_SH, EX_SW
    } aluop_e;

    typedef enum logic [2:0] {
        EX_RES_NOP = 3'd0,
        EX_RES_LOGIC,
        EX_RES_SHIFT,
        EX_RES_ARITH,
        EX_RES_LD_ST
    } alusel_e;

    // One instruction word, four field layouts
    typedef union packed {
        struct packed {
            logic [6:0]            func7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            func3;
            logic [REG_ADDR_W-1:0] rd;
            opcode_e               opcode;
        } r;
        struct packed {
            logic [11:0]           imm12;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            func3;
            logic [REG_ADDR_W-1:0] rd;
            opcode_e               opcode;
        } i;
        struct packed {
            logic [6:0]            imm_hi7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            func3;
            logic [4:0]            imm_lo5;
            opcode_e               opcode;
        } s;
        struct packed {
            logic [19:0]           imm20;
            logic [REG_ADDR_W-1:0] rd;
            opcode_e               opcode;
        } u;
    } inst_u;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] r1_addr;
        logic                  r1_read_enable;
        logic [REG_ADDR_W-1:0] r2_addr;
        logic                  r2_read_enable;
    } reg_req_t;

    typedef struct packed {
        logic                  wb;    // Write will happen
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } fwd_t;

    typedef struct packed {
        aluop_e  aluop;
        alusel_e alusel;
        logic    rd_enable;
        logic    use_imm;         // Immediate replaces rs2
    } dec_ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       r1;
        logic [XLEN-1:0]       r2;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_enable;
        aluop_e                aluop;
        alusel_e               alusel;
    } id_ex_t;

endpackage

`default_nettype wire

//--- design/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module inst_decoder import id_pkg::*; (
    input  inst_u     inst,
    output dec_ctrl_t dec_ctrl,
    output reg_req_t  reg_req
);

    logic exe_ok;
    logic exei_ok;

    // Shared by R-type and I-type, alt selects SUB/SRA
    function automatic dec_ctrl_t alu_decode(input logic [2:0] func3, input logic alt);
        dec_ctrl_t ctrl;
        ctrl = '0;
        ctrl.rd_enable = 1'b1;
        case (func3)
            3'b000: begin
                ctrl.aluop  = alt ? EX_SUB : EX_ADD;
                ctrl.alusel = EX_RES_ARITH;
            end
            3'b001: begin
                ctrl.aluop  = EX_SLL;
                ctrl.alusel = EX_RES_SHIFT;
            end
            3'b010: begin
                ctrl.aluop  = EX_SLT;
                ctrl.alusel = EX_RES_ARITH;
            end
            3'b011: begin
                ctrl.aluop  = EX_SLTU;
                ctrl.alusel = EX_RES_ARITH;
            end
            3'b100: begin
                ctrl.aluop  = EX_XOR;
                ctrl.alusel = EX_RES_LOGIC;
            end
            3'b101: begin
                ctrl.aluop  = alt ? EX_SRA : EX_SRL;
                ctrl.alusel = EX_RES_SHIFT;
            end
            3'b110: begin
                ctrl.aluop  = EX_OR;
                ctrl.alusel = EX_RES_LOGIC;
            end
            default: begin
                ctrl.aluop  = EX_AND;
                ctrl.alusel = EX_RES_LOGIC;
            end
        endcase
        return ctrl;
    endfunction

    // Alternate func7 only legal for SUB and SRA
    assign exe_ok = (inst.r.func7 == 7'b0000000) ||
                    (inst.r.func7 == 7'b0100000 &&
                     (inst.r.func3 == 3'b000 || inst.r.func3 == 3'b101));

    assign exei_ok = (inst.i.func3 == 3'b001) ? (inst.r.func7 == 7'b0000000) :
                     (inst.i.func3 == 3'b101) ? (inst.r.func7 == 7'b0000000 ||
                                                 inst.r.func7 == 7'b0100000) :
                     1'b1;

    always_comb begin
        dec_ctrl               = '0;
        reg_req.r1_addr        = inst.r.rs1;
        reg_req.r2_addr        = inst.r.rs2;
        reg_req.r1_read_enable = 1'b0;
        reg_req.r2_read_enable = 1'b0;
        case (inst.r.opcode)
            OP_EXE: begin
                if (exe_ok) begin
                    dec_ctrl               = alu_decode(inst.r.func3, inst.r.func7[5]);
                    reg_req.r1_read_enable = 1'b1;
                    reg_req.r2_read_enable = 1'b1;
                end
            end
            OP_EXEI: begin
                if (exei_ok) begin
                    dec_ctrl = alu_decode(inst.i.func3,
                                          inst.i.func3 == 3'b101 && inst.r.func7[5]);
                    dec_ctrl.use_imm       = 1'b1;
                    reg_req.r1_read_enable = 1'b1;
                end
            end
            OP_LUI: begin
                dec_ctrl.aluop     = EX_OR;       // 0 | imm
                dec_ctrl.alusel    = EX_RES_LOGIC;
                dec_ctrl.rd_enable = 1'b1;
                dec_ctrl.use_imm   = 1'b1;
            end
            OP_AUIPC: begin
                dec_ctrl.aluop     = EX_AUIPC;
                dec_ctrl.alusel    = EX_RES_ARITH;
                dec_ctrl.rd_enable = 1'b1;
            end
            OP_LOAD: begin
                case (inst.i.func3)
                    3'b000:  dec_ctrl.aluop = EX_LB;
                    3'b001:  dec_ctrl.aluop = EX_LH;
                    3'b010:  dec_ctrl.aluop = EX_LW;
                    3'b100:  dec_ctrl.aluop = EX_LBU;
                    3'b101:  dec_ctrl.aluop = EX_LHU;
                    default: dec_ctrl.aluop = EX_NOP;
                endcase
                if (dec_ctrl.aluop != EX_NOP) begin
                    dec_ctrl.alusel        = EX_RES_LD_ST;
                    dec_ctrl.rd_enable     = 1'b1;
                    reg_req.r1_read_enable = 1'b1;
                end
            end
            OP_STORE: begin
                case (inst.r.func3)
                    3'b000:  dec_ctrl.aluop = EX_SB;
                    3'b001:  dec_ctrl.aluop = EX_SH;
                    3'b010:  dec_ctrl.aluop = EX_SW;
                    default: dec_ctrl.aluop = EX_NOP;
                endcase
                if (dec_ctrl.aluop != EX_NOP) begin
                    dec_ctrl.alusel        = EX_RES_LD_ST;
                    reg_req.r1_read_enable = 1'b1;     // Base address
                    reg_req.r2_read_enable = 1'b1;     // Store data
                end
            end
            default: begin
                dec_ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/imm_gen.sv
`timescale 1ns/1ns
`default_nettype none

module imm_gen import id_pkg::*; (
    input  inst_u           inst,
    output logic [XLEN-1:0] imm
);

    logic is_shift;

    // SLLI / SRLI / SRAI carry a shift amount
    assign is_shift = (inst.i.func3 == 3'b001) || (inst.i.func3 == 3'b101);

    always_comb begin
        case (inst.i.opcode)
            OP_EXEI: begin
                if (is_shift) begin
                    imm = {{(XLEN-5){1'b0}}, inst.i.imm12[4:0]};
                end else begin
                    imm = {{(XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};
                end
            end
            OP_LOAD: begin
                imm = {{(XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};
            end
            OP_STORE: begin
                imm = {{(XLEN-12){inst.s.imm_hi7[6]}}, inst.s.imm_hi7, inst.s.imm_lo5};
            end
            OP_LUI, OP_AUIPC: begin
                imm = {inst.u.imm20, 12'b0};    // U format
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/operand_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module operand_fetch import id_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [XLEN-1:0]       pc,
    input  logic [REG_ADDR_W-1:0] rd,
    input  dec_ctrl_t             dec_ctrl,
    input  reg_req_t              reg_req,
    input  logic [XLEN-1:0]       imm,
    input  logic [XLEN-1:0]       r1_data,
    input  logic [XLEN-1:0]       r2_data,
    input  fwd_t                  ex_fwd,
    input  fwd_t                  mem_fwd,
    input  logic                  ld_flag,
    output id_ex_t                id_ex,
    output logic                  id_stall
);

    logic [XLEN:0]   src1;      // {stall, operand}
    logic [XLEN:0]   src2;
    logic [XLEN-1:0] r2_fallback;
    id_ex_t          id_ex_next;

    // Forwarding priority: load-use, then EX, then MEM, then register file
    function automatic logic [XLEN:0] pick_src(
        input logic [REG_ADDR_W-1:0] addr,
        input logic                  read_en,
        input logic [XLEN-1:0]       rf_data,
        input logic [XLEN-1:0]       fallback,
        input fwd_t                  ex,
        input fwd_t                  mem,
        input logic                  ld
    );
        logic          hit_ex;
        logic          hit_mem;
        logic [XLEN:0] res;
        hit_ex  = (ex.addr == addr);
        hit_mem = (mem.addr == addr);
        if (!read_en || addr == '0) begin
            res = {1'b0, fallback};
        end else if (ld && hit_ex) begin
            res = {1'b1, {XLEN{1'b0}}};   // Load result not ready yet
        end else if (ex.wb && hit_ex) begin
            res = {1'b0, ex.data};
        end else if (mem.wb && hit_mem) begin
            res = {1'b0, mem.data};
        end else begin
            res = {1'b0, rf_data};
        end
        return res;
    endfunction

    assign r2_fallback = dec_ctrl.use_imm ? imm : {XLEN{1'b0}};

    assign src1 = pick_src(reg_req.r1_addr, reg_req.r1_read_enable, r1_data,
                           {XLEN{1'b0}}, ex_fwd, mem_fwd, ld_flag);
    assign src2 = pick_src(reg_req.r2_addr, reg_req.r2_read_enable, r2_data,
                           r2_fallback, ex_fwd, mem_fwd, ld_flag);

    assign id_stall = src1[XLEN] | src2[XLEN];

    always_comb begin
        id_ex_next.pc        = pc;
        id_ex_next.r1        = src1[XLEN-1:0];
        id_ex_next.r2        = src2[XLEN-1:0];
        id_ex_next.imm       = imm;
        id_ex_next.rd        = rd;
        id_ex_next.rd_enable = dec_ctrl.rd_enable;
        id_ex_next.aluop     = dec_ctrl.aluop;
        id_ex_next.alusel    = dec_ctrl.alusel;
    end

    // ID/EX register, bubble is all zero
    always_ff @(posedge clk) begin
        if (rst || id_stall) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ex_next;
        end
    end

endmodule

`default_nettype wire

//--- design/id_stage.sv
`timescale 1ns/1ns
`default_nettype none

module id_stage import id_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [XLEN-1:0] pc,
    input  inst_u           inst,
    input  logic [XLEN-1:0] r1_data,
    input  logic [XLEN-1:0] r2_data,
    input  fwd_t            ex_fwd,
    input  fwd_t            mem_fwd,
    input  logic            ld_flag,
    output reg_req_t        reg_req,
    output id_ex_t          id_ex,
    output logic            id_stall
);

    dec_ctrl_t       dec_ctrl;
    logic [XLEN-1:0] imm;

    inst_decoder u_inst_decoder (
        .inst     (inst),
        .dec_ctrl (dec_ctrl),
        .reg_req  (reg_req)
    );

    imm_gen u_imm_gen (
        .inst (inst),
        .imm  (imm)
    );

    operand_fetch u_operand_fetch (
        .clk      (clk),
        .rst      (rst),
        .pc       (pc),
        .rd       (inst.r.rd),
        .dec_ctrl (dec_ctrl),
        .reg_req  (reg_req),
        .imm      (imm),
        .r1_data  (r1_data),
        .r2_data  (r2_data),
        .ex_fwd   (ex_fwd),
        .mem_fwd  (mem_fwd),
        .ld_flag  (ld_flag),
        .id_ex    (id_ex),
        .id_stall (id_stall)
    );

endmodule

`default_nettype wire

//--- tests/id_stage_chk.sv
`timescale 1ns/1ns
`default_nettype none

module id_stage_chk import id_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     ld_flag,
    input logic     id_stall,
    input reg_req_t reg_req,
    input id_ex_t   id_ex
);

    stall_needs_load: assert property (@(posedge clk) id_stall |-> ld_flag)
        else $error("id_stall raised while ld_flag is low");

    // Bubble enters ID/EX one edge later
    bubble_after_stall: assert property (@(posedge clk)
        (rst || id_stall) |=> (!id_ex.rd_enable && id_ex.aluop == EX_NOP))
        else $error("id_ex is not a bubble after stall or reset");

    stall_has_source: assert property (@(posedge clk) disable iff (rst)
        id_stall |-> ((reg_req.r1_read_enable && reg_req.r1_addr != '0) ||
                      (reg_req.r2_read_enable && reg_req.r2_addr != '0)))
        else $error("stall without a read of a nonzero register");

endmodule

bind id_stage id_stage_chk u_id_stage_chk (
    .clk      (clk),
    .rst      (rst),
    .ld_flag  (ld_flag),
    .id_stall (id_stall),
    .reg_req  (reg_req),
    .id_ex    (id_ex)
);

`default_nettype wire

//--- tests/id_stage_tb.sv
`timescale 1ns/1ns
`default_nettype none

module id_stage_tb import id_pkg::*; ();

    typedef struct packed {
        logic [XLEN-1:0] pc;
        inst_u           inst;
        logic [XLEN-1:0] r1_data;
        logic [XLEN-1:0] r2_data;
        fwd_t            ex_fwd;
        fwd_t            mem_fwd;
        logic            ld_flag;
        reg_req_t        req;
        logic            stall;
        id_ex_t          out;
    } vec_t;

    logic            clk;
    logic            rst;
    logic [XLEN-1:0] pc;
    inst_u           inst;
    logic [XLEN-1:0] r1_data;
    logic [XLEN-1:0] r2_data;
    fwd_t            ex_fwd;
    fwd_t            mem_fwd;
    logic            ld_flag;
    reg_req_t        reg_req;
    id_ex_t          id_ex;
    logic            id_stall;
    vec_t            vecs[$];
    int              cycles = 0;
    int              limit = 0;

    id_stage DUT (
        .clk      (clk),
        .rst      (rst),
        .pc       (pc),
        .inst     (inst),
        .r1_data  (r1_data),
        .r2_data  (r2_data),
        .ex_fwd   (ex_fwd),
        .mem_fwd  (mem_fwd),
        .ld_flag  (ld_flag),
        .reg_req  (reg_req),
        .id_ex    (id_ex),
        .id_stall (id_stall)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("Simulation failed");
            $fatal(1, "Timeout");
        end
    end

    function automatic inst_u r_type(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                     input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_EXE};
    endfunction

    function automatic inst_u i_type(input logic [11:0] imm12, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input opcode_e op);
        return {imm12, rs1, f3, rd, op};
    endfunction

    function automatic inst_u s_type(input logic [11:0] imm12, input logic [4:0] rs2, rs1,
                                     input logic [2:0] f3);
        return {imm12[11:5], rs2, rs1, f3, imm12[4:0], OP_STORE};
    endfunction

    function automatic inst_u u_type(input logic [19:0] imm20, input logic [4:0] rd,
                                     input opcode_e op);
        return {imm20, rd, op};
    endfunction

    function automatic reg_req_t reg_request(input logic [4:0] r1a, input logic r1e,
                                             input logic [4:0] r2a, input logic r2e);
        return {r1a, r1e, r2a, r2e};
    endfunction

    function automatic fwd_t forward(input logic wb, input logic [4:0] addr,
                                     input logic [XLEN-1:0] data);
        return {wb, addr, data};
    endfunction

    function automatic id_ex_t stage_out(input logic [XLEN-1:0] pc_v, r1, r2, imm,
                                         input logic [4:0] rd, input logic rd_en,
                                         input aluop_e op, input alusel_e sel);
        return {pc_v, r1, r2, imm, rd, rd_en, op, sel};
    endfunction

    task automatic add_row(input logic [XLEN-1:0] pc_v, input inst_u inst_v,
                           input logic [XLEN-1:0] r1_v, r2_v, input fwd_t ex_v, mem_v,
                           input logic ld_v, input reg_req_t req_v, input logic stall_v,
                           input id_ex_t out_v);
        vec_t v;
        v = {pc_v, inst_v, r1_v, r2_v, ex_v, mem_v, ld_v, req_v, stall_v, out_v};
        vecs.push_back(v);
    endtask

    task automatic build_table();
        fwd_t idle;
        idle = '0;
        add_row('h1000, r_type(7'h00, 2, 1, 3'b000, 3), 'h11, 'h22, idle, idle, 0,
                reg_request(1, 1, 2, 1), 0,
                stage_out('h1000, 'h11, 'h22, 0, 3, 1, EX_ADD, EX_RES_ARITH));
        add_row('h1004, r_type(7'h20, 2, 1, 3'b000, 4), 'h50, 'h30, idle, idle, 0,
                reg_request(1, 1, 2, 1), 0,
                stage_out('h1004, 'h50, 'h30, 0, 4, 1, EX_SUB, EX_RES_ARITH));
        add_row('h1008, r_type(7'h00, 6, 5, 3'b100, 7), 'hF0F0, 'h0FF0, idle, idle, 0,
                reg_request(5, 1, 6, 1), 0,
                stage_out('h1008, 'hF0F0, 'h0FF0, 0, 7, 1, EX_XOR, EX_RES_LOGIC));
        add_row('h100C, r_type(7'h00, 9, 8, 3'b001, 10), 'h1, 'h4, idle, idle, 0,
                reg_request(8, 1, 9, 1), 0,
                stage_out('h100C, 'h1, 'h4, 0, 10, 1, EX_SLL, EX_RES_SHIFT));
        add_row('h1010, r_type(7'h20, 12, 11, 3'b101, 13), 'h8000_0000, 'h3, idle, idle, 0,
                reg_request(11, 1, 12, 1), 0,
                stage_out('h1010, 'h8000_0000, 'h3, 0, 13, 1, EX_SRA, EX_RES_SHIFT));
        add_row('h1014, r_type(7'h00, 15, 14, 3'b011, 16), 'h5, 'h7, idle, idle, 0,
                reg_request(14, 1, 15, 1), 0,
                stage_out('h1014, 'h5, 'h7, 0, 16, 1, EX_SLTU, EX_RES_ARITH));
        // rs2 field of I-type is imm12[4:0]
        add_row('h1018, i_type(12'hFFD, 4, 3'b000, 5, OP_EXEI), 'h64, 'hDEAD, idle, idle, 0,
                reg_request(4, 1, 29, 0), 0,
                stage_out('h1018, 'h64, 'hFFFF_FFFD, 'hFFFF_FFFD, 5, 1, EX_ADD, EX_RES_ARITH));
        add_row('h101C, i_type(12'h0F0, 4, 3'b111, 6, OP_EXEI), 'h1234, 'hDEAD, idle, idle, 0,
                reg_request(4, 1, 16, 0), 0,
                stage_out('h101C, 'h1234, 'hF0, 'hF0, 6, 1, EX_AND, EX_RES_LOGIC));
        add_row('h1020, i_type(12'h005, 4, 3'b001, 7, OP_EXEI), 'h3, 'hDEAD, idle, idle, 0,
                reg_request(4, 1, 5, 0), 0,
                stage_out('h1020, 'h3, 'h5, 'h5, 7, 1, EX_SLL, EX_RES_SHIFT));
        add_row('h1024, i_type(12'h407, 4, 3'b101, 8, OP_EXEI), 'hFFFF_0000, 'hDEAD, idle,
                idle, 0, reg_request(4, 1, 7, 0), 0,
                stage_out('h1024, 'hFFFF_0000, 'h7, 'h7, 8, 1, EX_SRA, EX_RES_SHIFT));
        add_row('h1028, u_type(20'h12345, 9, OP_LUI), 'hDEAD, 'hBEEF, idle, idle, 0,
                reg_request(8, 0, 3, 0), 0,
                stage_out('h1028, 0, 'h1234_5000, 'h1234_5000, 9, 1, EX_OR, EX_RES_LOGIC));
        add_row('h102C, u_type(20'hABCDE, 10, OP_AUIPC), 'hDEAD, 'hBEEF, idle, idle, 0,
                reg_request(27, 0, 28, 0), 0,
                stage_out('h102C, 0, 0, 'hABCD_E000, 10, 1, EX_AUIPC, EX_RES_ARITH));
        add_row('h1030, i_type(12'h010, 12, 3'b010, 11, OP_LOAD), 'h2000, 'hBEEF, idle, idle,
                0, reg_request(12, 1, 16, 0), 0,
                stage_out('h1030, 'h2000, 0, 'h10, 11, 1, EX_LW, EX_RES_LD_ST));
        add_row('h1034, s_type(12'hFF8, 13, 14, 3'b001), 'h3000, 'hCAFE, idle, idle, 0,
                reg_request(14, 1, 13, 1), 0,
                stage_out('h1034, 'h3000, 'hCAFE, 'hFFFF_FFF8, 24, 0, EX_SH, EX_RES_LD_ST));
        add_row('h1038, r_type(7'h00, 2, 1, 3'b000, 3), 'h11, 'h22, forward(1, 1, 'hAAAA),
                forward(1, 1, 'hBBBB), 0, reg_request(1, 1, 2, 1), 0,
                stage_out('h1038, 'hAAAA, 'h22, 0, 3, 1, EX_ADD, EX_RES_ARITH));
        add_row('h103C, r_type(7'h00, 2, 1, 3'b000, 3), 'h11, 'h22, forward(1, 1, 'hAAAA),
                forward(1, 2, 'hCCCC), 0, reg_request(1, 1, 2, 1), 0,
                stage_out('h103C, 'hAAAA, 'hCCCC, 0, 3, 1, EX_ADD, EX_RES_ARITH));
        // x0 sources ignore forwards and the load in execute
        add_row('h1040, r_type(7'h00, 0, 0, 3'b000, 3), 'h11, 'h22, forward(1, 0, 'hAAAA),
                forward(1, 0, 'hBBBB), 1, reg_request(0, 1, 0, 1), 0,
                stage_out('h1040, 0, 0, 0, 3, 1, EX_ADD, EX_RES_ARITH));
        add_row('h1044, r_type(7'h00, 2, 1, 3'b000, 3), 'h11, 'h22, forward(1, 2, 'hAAAA),
                idle, 1, reg_request(1, 1, 2, 1), 1, '0);
        add_row('h1044, r_type(7'h00, 2, 1, 3'b000, 3), 'h11, 'h22, idle,
                forward(1, 2, 'hD00D), 0, reg_request(1, 1, 2, 1), 0,
                stage_out('h1044, 'h11, 'hD00D, 0, 3, 1, EX_ADD, EX_RES_ARITH));
        add_row('h1048, 32'h0000_007F, 'h11, 'h22, idle, idle, 0,
                reg_request(0, 0, 0, 0), 0,
                stage_out('h1048, 0, 0, 0, 0, 0, EX_NOP, EX_RES_NOP));
    endtask

    task automatic report_mismatch(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "Stopping at first mismatch");
    endtask

    task automatic check_reg_req(input reg_req_t exp, input int idx);
        if (reg_req !== exp) begin
            report_mismatch($sformatf("row %0d reg_req %h, expected %h", idx, reg_req, exp));
        end
    endtask

    task automatic check_stall(input logic exp, input int idx);
        if (id_stall !== exp) begin
            report_mismatch($sformatf("row %0d id_stall %b, expected %b", idx, id_stall, exp));
        end
    endtask

    task automatic check_id_ex(input id_ex_t exp, input int idx);
        if (id_ex !== exp) begin
            report_mismatch($sformatf("row %0d id_ex %h, expected %h", idx, id_ex, exp));
        end
    endtask

    initial begin
        clk     = 1'b0;
        rst     = 1'b1;
        pc      = 'h0FFC;
        inst    = r_type(7'h00, 2, 1, 3'b000, 3);
        r1_data = '0;
        r2_data = '0;
        ex_fwd  = '0;
        mem_fwd = '0;
        ld_flag = 1'b0;
        build_table();
        limit = 5 + 2 * vecs.size() + 20;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_id_ex('0, -1);                    // Reset bubble
        for (int i = 0; i < vecs.size(); i++) begin
            @(posedge clk);
            pc      <= vecs[i].pc;
            inst    <= vecs[i].inst;
            r1_data <= vecs[i].r1_data;
            r2_data <= vecs[i].r2_data;
            ex_fwd  <= vecs[i].ex_fwd;
            mem_fwd <= vecs[i].mem_fwd;
            ld_flag <= vecs[i].ld_flag;
            @(negedge clk);
            check_reg_req(vecs[i].req, i);
            check_stall(vecs[i].stall, i);
            if (i > 0) begin
                check_id_ex(vecs[i-1].out, i - 1);  // Previous row lands one edge later
            end
        end
        @(posedge clk);
        @(negedge clk);
        check_id_ex(vecs[vecs.size()-1].out, vecs.size() - 1);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
design/id_pkg.sv
design/inst_decoder.sv
design/imm_gen.sv
design/operand_fetch.sv
design/id_stage.sv
tests/id_stage_chk.sv
tests/id_stage_tb.sv
